// File: logic/cnn_consts.svh
`ifndef CNN_CONSTS_SVH
`define CNN_CONSTS_SVH

// memory interface
`define CNN_WORD_BITS       32
`define CNN_ADDR_BITS       32

// one feature or weight byte
`define CNN_ELEM_BITS       8
`define CNN_ELEMS_PER_WORD  4

// dot product split over the PEs, 4 x 25 = 100 taps
`define CNN_PE_TAPS         25
`define CNN_PE_COUNT        4
`define CNN_FEAT_WORDS      25  // words per feature vector or weight row

// class counts per mode
`define CNN_DIGIT_CLASSES   10
`define CNN_LETTER_CLASSES  27

`endif

// File: logic/cnn_pkg.sv
`include "cnn_consts.svh"

package cnn_pkg;

  // memory side
  typedef logic [`CNN_WORD_BITS-1:0] word_t;
  typedef logic [`CNN_ADDR_BITS-1:0] byte_addr_t;

  // elements unpacked from memory words
  typedef logic        [`CNN_ELEM_BITS-1:0] feat_t;  // activations, unsigned
  typedef logic signed [`CNN_ELEM_BITS-1:0] wgt_t;   // weights, two's complement

  // PE partial sums and the final class score
  typedef logic signed [31:0] psum_t;

  typedef logic [7:0] class_t;     // up to 27 classes in letter mode
  typedef logic [4:0] word_idx_t;  // 0..24 within a row

endpackage

// File: logic/word_cache.sv
`timescale 1ns/1ps
`include "cnn_consts.svh"

module word_cache import cnn_pkg::*; #(
  parameter type T_ELEM = feat_t
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      i_wr,
  input  word_idx_t i_index,
  input  word_t     i_data,
  output T_ELEM     o_elems [`CNN_FEAT_WORDS*`CNN_ELEMS_PER_WORD]
);

  localparam int NUM_ELEMS = `CNN_FEAT_WORDS * `CNN_ELEMS_PER_WORD;

  // one word fills four neighbouring elements, msb byte first
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < NUM_ELEMS; i++) begin
        o_elems[i] <= '0;
      end
    end else if (i_wr) begin
      for (int e = 0; e < `CNN_ELEMS_PER_WORD; e++) begin
        // {index, e} is 4*index + e
        o_elems[{i_index, 2'(e)}] <=
          T_ELEM'(i_data[`CNN_WORD_BITS-1 - e*`CNN_ELEM_BITS -: `CNN_ELEM_BITS]);
      end
    end
  end

endmodule

// File: logic/dot_pe.sv
`timescale 1ns/1ps
`include "cnn_consts.svh"

module dot_pe import cnn_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  i_exec,
  input  feat_t i_feat [`CNN_PE_TAPS],
  input  wgt_t  i_wgt  [`CNN_PE_TAPS],
  output psum_t o_psum
);

  psum_t sum;

  // unsigned feature times signed weight over 25 taps
  always_comb begin
    sum = '0;
    for (int t = 0; t < `CNN_PE_TAPS; t++) begin
      sum = sum + psum_t'(i_feat[t]) * psum_t'(i_wgt[t]);  // weight sign extended
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_psum <= '0;
    end else if (i_exec) begin
      o_psum <= sum;  // holds until the next row
    end
  end

endmodule

// File: logic/fc_sequencer.sv
`timescale 1ns/1ps
`include "cnn_consts.svh"

module fc_sequencer import cnn_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       i_start,
  input  logic       i_mode,      // 1 number, 0 letter
  output byte_addr_t o_feat_addr,
  output byte_addr_t o_wgt_addr,
  output logic       o_feat_wr,
  output logic       o_wgt_wr,
  output word_idx_t  o_wr_index,
  output logic       o_exec,
  output logic       o_score_en,
  output logic       o_clear,
  output class_t     o_class,
  output logic       o_done
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOAD_F,
    S_LOAD_W,
    S_EXEC,
    S_SCORE,
    S_DONE
  } state_t;

  // 25 issue cycles plus one to catch the last read
  localparam word_idx_t LAST_CYCLE = word_idx_t'(`CNN_FEAT_WORDS);
  localparam word_idx_t LAST_WORD  = word_idx_t'(`CNN_FEAT_WORDS - 1);

  state_t    state;
  word_idx_t cnt;         // cycle within a load phase
  class_t    class_lim;   // latched at start
  logic      start_ok;
  logic      issue;       // an address goes out this cycle
  logic      last_class;

  assign start_ok   = i_start && (state == S_IDLE || state == S_DONE);
  assign issue      = (cnt != LAST_CYCLE);
  assign last_class = (o_class == class_lim - 8'd1);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= S_IDLE;
      cnt       <= '0;
      class_lim <= '0;
      o_class   <= '0;
    end else begin
      case (state)
        S_IDLE, S_DONE: begin
          if (start_ok) begin
            state     <= S_LOAD_F;
            cnt       <= '0;
            o_class   <= '0;
            class_lim <= i_mode ? 8'(`CNN_DIGIT_CLASSES) : 8'(`CNN_LETTER_CLASSES);
          end
        end
        S_LOAD_F, S_LOAD_W: begin
          if (cnt == LAST_CYCLE) begin
            state <= (state == S_LOAD_F) ? S_LOAD_W : S_EXEC;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 5'd1;
          end
        end
        S_EXEC: state <= S_SCORE;
        S_SCORE: begin
          if (last_class) begin
            state <= S_DONE;
          end else begin
            state   <= S_LOAD_W;
            o_class <= o_class + 8'd1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // addresses lead the cache strobes by one cycle, matching the RAM latency
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_feat_addr <= '0;
      o_wgt_addr  <= '0;
      o_feat_wr   <= 1'b0;
      o_wgt_wr    <= 1'b0;
      o_wr_index  <= '0;
      o_clear     <= 1'b0;
    end else begin
      o_clear    <= start_ok;
      o_feat_wr  <= (state == S_LOAD_F) && issue;
      o_wgt_wr   <= (state == S_LOAD_W) && issue;
      o_wr_index <= cnt;
      if (state == S_LOAD_F && issue) begin
        o_feat_addr <= (cnt == LAST_WORD) ? '0 : o_feat_addr + 32'd4;
      end
      // weight rows are contiguous, so the pointer runs on across classes
      if (state == S_LOAD_W && issue) begin
        o_wgt_addr <= (cnt == LAST_WORD && last_class) ? '0 : o_wgt_addr + 32'd4;
      end
    end
  end

  assign o_exec     = (state == S_EXEC);
  assign o_score_en = (state == S_SCORE);
  assign o_done     = (state == S_DONE);

endmodule

// File: logic/score_argmax.sv
`timescale 1ns/1ps
`include "cnn_consts.svh"

module score_argmax import cnn_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   i_clear,
  input  logic   i_score_en,
  input  class_t i_class,
  input  psum_t  i_psum [`CNN_PE_COUNT],
  output class_t o_result
);

  psum_t total;
  psum_t score;
  psum_t best;   // running maximum, never negative

  // sum of the PE outputs
  always_comb begin
    total = '0;
    for (int p = 0; p < `CNN_PE_COUNT; p++) begin
      total = total + i_psum[p];
    end
  end

  assign score = total[31] ? '0 : total;  // relu

  // strict compare keeps the lowest index on ties
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      best     <= '0;
      o_result <= '0;
    end else if (i_clear) begin
      best     <= '0;
      o_result <= '0;
    end else if (i_score_en && score > best) begin
      best     <= score;
      o_result <= i_class;
    end
  end

endmodule

// File: logic/fc_classifier.sv
`timescale 1ns/1ps
`include "cnn_consts.svh"

module fc_classifier import cnn_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       i_start,
  input  logic       i_mode,
  output byte_addr_t o_feat_addr,
  output byte_addr_t o_wgt_addr,
  input  word_t      i_feat_data,
  input  word_t      i_wgt_data,
  output logic       o_done,
  output class_t     o_result
);

  localparam int NUM_ELEMS = `CNN_FEAT_WORDS * `CNN_ELEMS_PER_WORD;

  logic      feat_wr;
  logic      wgt_wr;
  word_idx_t wr_index;
  logic      exec;
  logic      score_en;
  logic      clear;
  class_t    cur_class;
  feat_t     feat_elems [NUM_ELEMS];
  wgt_t      wgt_elems  [NUM_ELEMS];
  psum_t     pe_psum    [`CNN_PE_COUNT];

  fc_sequencer u_seq (
    .clk        (clk),
    .rst        (rst),
    .i_start    (i_start),
    .i_mode     (i_mode),
    .o_feat_addr(o_feat_addr),
    .o_wgt_addr (o_wgt_addr),
    .o_feat_wr  (feat_wr),
    .o_wgt_wr   (wgt_wr),
    .o_wr_index (wr_index),
    .o_exec     (exec),
    .o_score_en (score_en),
    .o_clear    (clear),
    .o_class    (cur_class),
    .o_done     (o_done)
  );

  word_cache #(.T_ELEM(feat_t)) feat_cache (
    .clk    (clk),
    .rst    (rst),
    .i_wr   (feat_wr),
    .i_index(wr_index),
    .i_data (i_feat_data),
    .o_elems(feat_elems)
  );

  word_cache #(.T_ELEM(wgt_t)) wgt_cache (
    .clk    (clk),
    .rst    (rst),
    .i_wr   (wgt_wr),
    .i_index(wr_index),
    .i_data (i_wgt_data),
    .o_elems(wgt_elems)
  );

  // each PE owns a contiguous quarter of the vector
  for (genvar g = 0; g < `CNN_PE_COUNT; g++) begin : pe_array
    localparam int LO = g * `CNN_PE_TAPS;
    localparam int HI = LO + `CNN_PE_TAPS - 1;

    dot_pe u_pe (
      .clk   (clk),
      .rst   (rst),
      .i_exec(exec),
      .i_feat(feat_elems[LO:HI]),
      .i_wgt (wgt_elems[LO:HI]),
      .o_psum(pe_psum[g])
    );
  end

  score_argmax u_argmax (
    .clk       (clk),
    .rst       (rst),
    .i_clear   (clear),
    .i_score_en(score_en),
    .i_class   (cur_class),
    .i_psum    (pe_psum),
    .o_result  (o_result)
  );

endmodule

// File: dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter real PERIOD_NS = 10.0
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;  // free running
  end

endmodule

// File: dv/fc_classifier_asserts.sv
`timescale 1ns/1ps
`include "cnn_consts.svh"

module fc_classifier_asserts import cnn_pkg::*; (
  input logic       clk,
  input logic       rst,
  input logic       i_start,
  input logic       i_mode,
  input logic       i_done,
  input byte_addr_t i_feat_addr,
  input byte_addr_t i_wgt_addr,
  input class_t     i_result
);

  int unsigned fail_count = 0;
  logic        busy;
  class_t      limit;  // class count of the current run

  // shadow of the accepted start, a start while busy is dropped
  always @(posedge clk or posedge rst) begin
    if (rst) begin
      busy  <= 1'b0;
      limit <= 8'(`CNN_DIGIT_CLASSES);
    end else if (i_start && (!busy || i_done)) begin
      busy  <= 1'b1;
      limit <= i_mode ? 8'(`CNN_DIGIT_CLASSES) : 8'(`CNN_LETTER_CLASSES);
    end else if (i_done) begin
      busy <= 1'b0;
    end
  end

  reset_state: assert property (@(posedge clk) (rst || $past(rst)) |->
      (!i_done && i_result == '0 && i_feat_addr == '0 && i_wgt_addr == '0))
    else begin
      fail_count++;
      $error("outputs not at their reset values");
    end

  done_holds: assert property (@(posedge clk) disable iff (rst)
      (i_done && !i_start) |=> i_done)
    else begin
      fail_count++;
      $error("done dropped without a start");
    end

  done_falls: assert property (@(posedge clk) disable iff (rst)
      (i_done && i_start) |=> !i_done)
    else begin
      fail_count++;
      $error("done still high after an accepted start");
    end

  addr_aligned: assert property (@(posedge clk)
      i_feat_addr[1:0] == 2'b00 && i_wgt_addr[1:0] == 2'b00)
    else begin
      fail_count++;
      $error("memory address not word aligned");
    end

  addr_range: assert property (@(posedge clk) disable iff (rst)
      i_feat_addr < 32'd100 && i_wgt_addr < byte_addr_t'(limit) * 32'd100)
    else begin
      fail_count++;
      $error("memory address beyond the vector or weight rows");
    end

  result_range: assert property (@(posedge clk) disable iff (rst)
      i_done |-> i_result < limit)
    else begin
      fail_count++;
      $error("result index beyond the class count");
    end

endmodule

bind fc_classifier fc_classifier_asserts u_asserts (
  .clk        (clk),
  .rst        (rst),
  .i_start    (i_start),
  .i_mode     (i_mode),
  .i_done     (o_done),
  .i_feat_addr(o_feat_addr),
  .i_wgt_addr (o_wgt_addr),
  .i_result   (o_result)
);

// File: dv/fc_classifier_tb.sv
`timescale 1ns/1ps
`include "cnn_consts.svh"

module fc_classifier_tb import cnn_pkg::*; ();

  localparam int ELEMS      = `CNN_FEAT_WORDS * `CNN_ELEMS_PER_WORD;
  localparam int WGT_WORDS  = `CNN_LETTER_CLASSES * `CNN_FEAT_WORDS;
  localparam int LAT_DIGIT  = 26 + 28 * `CNN_DIGIT_CLASSES + 1;
  localparam int LAT_LETTER = 26 + 28 * `CNN_LETTER_CLASSES + 1;
  // three runs in number mode, two in letter mode, reset and slack
  localparam int LIMIT_NS   = 10 * (5 + 3 * LAT_DIGIT + 2 * LAT_LETTER + 100);

  logic        clk;
  logic        rst;
  logic        start;
  logic        mode;
  byte_addr_t  feat_addr;
  byte_addr_t  wgt_addr;
  word_t       feat_data;
  word_t       wgt_data;
  logic        done;
  class_t      result;
  word_t       feat_mem [`CNN_FEAT_WORDS];
  word_t       wgt_mem  [WGT_WORDS];
  word_idx_t   feat_ptr;
  logic [9:0]  wgt_ptr;
  logic [31:0] lfsr;

  tb_clock #(.PERIOD_NS(10.0)) clock_gen (.o_clk(clk));

  fc_classifier UUT (
    .clk        (clk),
    .rst        (rst),
    .i_start    (start),
    .i_mode     (mode),
    .o_feat_addr(feat_addr),
    .o_wgt_addr (wgt_addr),
    .i_feat_data(feat_data),
    .i_wgt_data (wgt_data),
    .o_done     (done),
    .o_result   (result)
  );

  // rams, address seen in one cycle and its word shown in the next
  always @(posedge clk) begin
    #1;
    feat_data = feat_mem[feat_ptr];
    wgt_data  = wgt_mem[wgt_ptr];
    feat_ptr  = word_idx_t'(feat_addr >> 2);
    wgt_ptr   = 10'(wgt_addr >> 2);
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic int feat_elem(input int i);
    word_t w;
    w = feat_mem[i / 4];
    return int'(w[31 - 8 * (i % 4) -: 8]);  // unsigned byte
  endfunction

  function automatic int wgt_elem(input int k, input int i);
    word_t w;
    byte   b;
    w = wgt_mem[k * `CNN_FEAT_WORDS + i / 4];
    b = w[31 - 8 * (i % 4) -: 8];
    return int'(b);  // signed byte
  endfunction

  // relu on each score, strict greater so the lowest index wins ties
  function automatic int ref_argmax(input int classes);
    int best;
    int best_k;
    int score;
    best   = 0;
    best_k = 0;
    for (int k = 0; k < classes; k++) begin
      score = 0;
      for (int i = 0; i < ELEMS; i++) begin
        score += feat_elem(i) * wgt_elem(k, i);
      end
      if (score < 0) score = 0;
      if (score > best) begin
        best   = score;
        best_k = k;
      end
    end
    return best_k;
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    assert (actual == expected) else begin
      $display("FAIL %s expected %0d actual %0d", name, expected, actual);
      $display("Something failed");
      $fatal(1, "value check stopped the run");
    end
  endtask

  task automatic fill_random();
    foreach (feat_mem[j]) begin
      feat_mem[j] = rand_bits(32);
    end
    foreach (wgt_mem[j]) begin
      wgt_mem[j] = rand_bits(32);
    end
  endtask

  // latency counted in edges from the one that raises start
  task automatic run_classifier(input string name, input logic num_mode, input logic poke);
    int classes;
    int expected;
    int cycles;
    classes  = num_mode ? `CNN_DIGIT_CLASSES : `CNN_LETTER_CLASSES;
    expected = ref_argmax(classes);
    @(posedge clk);
    #1;
    start  = 1'b1;
    mode   = num_mode;
    cycles = 0;
    while (cycles == 0 || !done) begin
      @(posedge clk);
      #1;
      cycles++;
      start = poke && cycles == 40;  // start while busy
      mode  = !num_mode;             // only sampled at start
    end
    check_value({name, " latency"}, 26 + 28 * classes + 1, cycles);
    check_value({name, " result"}, expected, int'(result));
  endtask

  initial begin
    rst       = 1'b1;
    start     = 1'b0;
    mode      = 1'b0;
    feat_data = '0;
    wgt_data  = '0;
    feat_ptr  = '0;
    wgt_ptr   = '0;
    lfsr      = 32'd67922;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    fill_random();
    run_classifier("number mode", 1'b1, 1'b0);
    fill_random();
    run_classifier("letter mode", 1'b0, 1'b0);

    // all weights negative, no feature byte zero
    foreach (feat_mem[j]) begin
      feat_mem[j] = rand_bits(32) | 32'h0101_0101;
    end
    foreach (wgt_mem[j]) begin
      wgt_mem[j] = rand_bits(32) | 32'h8080_8080;
    end
    run_classifier("relu all zero", 1'b1, 1'b0);
    check_value("relu all zero class", 0, int'(result));

    for (int j = 0; j < `CNN_FEAT_WORDS; j++) begin
      wgt_mem[7 * `CNN_FEAT_WORDS + j] = '0;
    end
    wgt_mem[7 * `CNN_FEAT_WORDS + 12] = 32'h0000_0500;  // element 50 of class 7 is +5
    run_classifier("relu single", 1'b1, 1'b0);
    check_value("relu single class", 7, int'(result));

    fill_random();
    run_classifier("busy start", 1'b0, 1'b1);
    @(posedge clk);
    if (UUT.u_asserts.fail_count == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("Something failed");
      $fatal(1, "protocol assertions failed");
    end
  end

  initial begin
    #(LIMIT_NS);
    $display("watchdog expired before the tests finished");
    $display("Something failed");
    $fatal(1, "timeout");
  end

endmodule

// File: verilog.f
+incdir+logic
logic/cnn_pkg.sv
logic/word_cache.sv
logic/dot_pe.sv
logic/fc_sequencer.sv
logic/score_argmax.sv
logic/fc_classifier.sv
dv/tb_clock.sv
dv/fc_classifier_asserts.sv
dv/fc_classifier_tb.sv

// File: run.sh
#!/bin/sh
# Verilator build and run of the fc_classifier testbench

verilator --binary --timing --assert -f verilog.f --top-module fc_classifier_tb -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Something failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
echo "simulation passed"
exit 0
